//--- src/periphPkg.sv
//--------------------------------------------------------------------------
// Shared widths, address map and register offsets for the timer subsystem.
//--------------------------------------------------------------------------
package periphPkg;

	// Bus widths.
	localparam int DATA_W   = 16;
	localparam int ADDR_W   = 4;
	localparam int REG_W    = 2;
	localparam int REGION_W = ADDR_W - REG_W;

	// Region codes, top address bits.
	localparam logic [REGION_W-1:0] REGION_TMR0 = 2'd0;
	localparam logic [REGION_W-1:0] REGION_TMR1 = 2'd1;
	localparam logic [REGION_W-1:0] REGION_INTC = 2'd2;
	// Region 3 is left unmapped.

	// Timer register offsets.
	localparam logic [REG_W-1:0] TMR_CTRL  = 2'd0;
	localparam logic [REG_W-1:0] TMR_COUNT = 2'd1;
	localparam logic [REG_W-1:0] TMR_MAX   = 2'd2;

	// Interrupt controller offsets.
	localparam logic [REG_W-1:0] INTC_PEND = 2'd0;
	localparam logic [REG_W-1:0] INTC_MASK = 2'd1;

	// Timer control register layout.
	localparam int PRE_W        = 4;
	localparam int CTRL_EN_BIT  = 0;
	localparam int CTRL_PRE_LSB = 4;

	// One source per timer.
	localparam int NUM_IRQ = 2;

	// Granted host.
	typedef enum logic {HOST_CPU = 1'b0, HOST_DBG = 1'b1} hostSel_t;

endpackage

//--- src/memBusIf.sv
//--------------------------------------------------------------------------
// Single-cycle memory-map bus shared by arbiter, decoder and devices.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

interface memBusIf
	import periphPkg::*;
();

	// Access signals.
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wrData;
	logic              wrEn;
	logic [DATA_W-1:0] rdData;

	// Marks a valid access to this bus segment.
	logic              sel;

	// Host side drives the access.
	modport host (
		output addr, wrData, wrEn, sel,
		input  rdData
	);

	// Device side answers with read data.
	modport device (
		input  addr, wrData, wrEn, sel,
		output rdData
	);

endinterface

//--- src/busArbiter.sv
//--------------------------------------------------------------------------
// Round-robin arbiter putting the CPU or debug host onto the shared bus.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module busArbiter
	import periphPkg::*;
(
	input  logic              i_clk,
	input  logic              i_rstN,

	// CPU data port.
	input  logic              i_cpuReq,
	input  logic [ADDR_W-1:0] i_cpuAddr,
	input  logic [DATA_W-1:0] i_cpuWrData,
	input  logic              i_cpuWrEn,
	output logic              o_cpuGnt,
	output logic [DATA_W-1:0] o_cpuRdData,

	// Debug port.
	input  logic              i_dbgReq,
	input  logic [ADDR_W-1:0] i_dbgAddr,
	input  logic [DATA_W-1:0] i_dbgWrData,
	input  logic              i_dbgWrEn,
	output logic              o_dbgGnt,
	output logic [DATA_W-1:0] o_dbgRdData,

	// Shared bus.
	memBusIf.host             busM
);

	hostSel_t lastGnt;
	hostSel_t winner;
	logic     anyReq;

	//----------------------------------------------------------------------
	// Winner selection.
	assign anyReq = i_cpuReq | i_dbgReq;

	always_comb begin
		winner = HOST_CPU;
		if (i_cpuReq && i_dbgReq) begin
			// Tie goes to the host not served last.
			winner = (lastGnt == HOST_CPU) ? HOST_DBG : HOST_CPU;
		end else if (i_dbgReq) begin
			winner = HOST_DBG;
		end
	end

	// Last grant; starts as debug so the CPU wins the first tie.
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			lastGnt <= HOST_DBG;
		end else if (anyReq) begin
			lastGnt <= winner;
		end
	end

	//----------------------------------------------------------------------
	// Grants, valid only with a request.
	assign o_cpuGnt = anyReq & (winner == HOST_CPU);
	assign o_dbgGnt = anyReq & (winner == HOST_DBG);

	// Winner's access onto the bus.
	assign busM.sel    = anyReq;
	assign busM.addr   = (winner == HOST_DBG) ? i_dbgAddr : i_cpuAddr;
	assign busM.wrData = (winner == HOST_DBG) ? i_dbgWrData : i_cpuWrData;
	assign busM.wrEn   = anyReq & ((winner == HOST_DBG) ? i_dbgWrEn : i_cpuWrEn);

	// Read data back to the granted host only.
	assign o_cpuRdData = o_cpuGnt ? busM.rdData : '0;
	assign o_dbgRdData = o_dbgGnt ? busM.rdData : '0;

endmodule

//--- src/periphDecoder.sv
//--------------------------------------------------------------------------
// Region decoder: device selects from the shared bus and read data return.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module periphDecoder
	import periphPkg::*;
(
	memBusIf.device busS,
	memBusIf.host   tmr0M,
	memBusIf.host   tmr1M,
	memBusIf.host   intcM
);

	logic [REGION_W-1:0] region;
	logic [ADDR_W-1:0]   regAddr;

	// Region from top bits; devices see only the offset.
	assign region  = busS.addr[ADDR_W-1:REG_W];
	assign regAddr = {{REGION_W{1'b0}}, busS.addr[REG_W-1:0]};

	//----------------------------------------------------------------------
	// Device selects.
	assign tmr0M.sel = busS.sel & (region == REGION_TMR0);
	assign tmr1M.sel = busS.sel & (region == REGION_TMR1);
	assign intcM.sel = busS.sel & (region == REGION_INTC);

	// Offset and data fan out.
	assign tmr0M.addr   = regAddr;
	assign tmr0M.wrData = busS.wrData;
	assign tmr0M.wrEn   = busS.wrEn;
	assign tmr1M.addr   = regAddr;
	assign tmr1M.wrData = busS.wrData;
	assign tmr1M.wrEn   = busS.wrEn;
	assign intcM.addr   = regAddr;
	assign intcM.wrData = busS.wrData;
	assign intcM.wrEn   = busS.wrEn;

	//----------------------------------------------------------------------
	// Read data mux.
	always_comb begin
		case (region)
			REGION_TMR0: busS.rdData = tmr0M.rdData;
			REGION_TMR1: busS.rdData = tmr1M.rdData;
			REGION_INTC: busS.rdData = intcM.rdData;
			// Unmapped region.
			default:     busS.rdData = '0;
		endcase
	end

endmodule

//--- src/timer.sv
//--------------------------------------------------------------------------
// 16-bit up-counter with prescale, max count and one-cycle wrap interrupt.
// Registers: control (enable, prescale), count and max count.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module timer
	import periphPkg::*;
(
	input  logic   i_clk,
	input  logic   i_rstN,
	memBusIf.device bus,
	input  logic   i_smIsBooted,
	input  logic   i_smStartPause,
	output logic   o_intTMR
);

	// Register offset.
	logic [REG_W-1:0]  regOff;

	// Write strobes.
	logic              isCtrlWr;
	logic              isCntWr;
	logic              isMaxWr;

	// Counter state controls.
	logic              doPause;
	logic              isPreMatch;
	logic              isMaxMatch;
	logic              doInc;

	// Registers.
	logic              enableQ;
	logic [PRE_W-1:0]  preQ;
	logic [PRE_W-1:0]  scaleQ;
	logic [DATA_W-1:0] cntQ;
	logic [DATA_W-1:0] maxQ;
	logic              intQ;

	// Control read-back.
	logic [DATA_W-1:0] ctrlRd;

	//----------------------------------------------------------------------
	// Address and state controls.
	assign regOff     = bus.addr[REG_W-1:0];
	assign isCtrlWr   = bus.sel & bus.wrEn & (regOff == TMR_CTRL);
	assign isCntWr    = bus.sel & bus.wrEn & (regOff == TMR_COUNT);
	assign isMaxWr    = bus.sel & bus.wrEn & (regOff == TMR_MAX);
	assign doPause    = ~i_smIsBooted | i_smStartPause;
	assign isPreMatch = (scaleQ == preQ);
	assign isMaxMatch = (cntQ == maxQ);
	assign doInc      = isPreMatch & enableQ & ~doPause;

	//----------------------------------------------------------------------
	// Control and max registers.
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			enableQ <= 1'b0;
			preQ    <= '0;
			maxQ    <= '0;
		end else begin
			if (isCtrlWr) begin
				enableQ <= bus.wrData[CTRL_EN_BIT];
				preQ    <= bus.wrData[CTRL_PRE_LSB +: PRE_W];
			end
			if (isMaxWr)
				maxQ <= bus.wrData;
		end
	end

	// Prescaler; restarts on match, control write or pause.
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN)
			scaleQ <= '0;
		else if (isPreMatch || isCtrlWr || doPause)
			scaleQ <= '0;
		else
			scaleQ <= scaleQ + PRE_W'(1);
	end

	//----------------------------------------------------------------------
	// Count register.
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			cntQ <= '0;
		end else if (isMaxWr) begin
			// New max restarts the count.
			cntQ <= '0;
		end else if (isCntWr) begin
			cntQ <= bus.wrData;
		end else if (doInc) begin
			cntQ <= isMaxMatch ? '0 : cntQ + DATA_W'(1);
		end
	end

	// Wrap pulse, one cycle.
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN)
			intQ <= 1'b0;
		else
			intQ <= isMaxMatch & doInc;
	end

	assign o_intTMR = intQ;

	//----------------------------------------------------------------------
	// Read data.
	always_comb begin
		ctrlRd                             = '0;
		ctrlRd[CTRL_EN_BIT]                = enableQ;
		ctrlRd[CTRL_PRE_LSB +: PRE_W]      = preQ;
	end

	always_comb begin
		case (regOff)
			TMR_CTRL:  bus.rdData = ctrlRd;
			TMR_COUNT: bus.rdData = cntQ;
			TMR_MAX:   bus.rdData = maxQ;
			default:   bus.rdData = '0;
		endcase
	end

endmodule

//--- src/intCtrl.sv
//--------------------------------------------------------------------------
// Interrupt controller: pending and mask registers, one registered line.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module intCtrl
	import periphPkg::*;
(
	input  logic               i_clk,
	input  logic               i_rstN,
	memBusIf.device            bus,
	input  logic [NUM_IRQ-1:0] i_irqSrc,
	output logic               o_irq
);

	logic [REG_W-1:0]   regOff;
	logic               isPendWr;
	logic               isMaskWr;
	logic [NUM_IRQ-1:0] pendQ;
	logic [NUM_IRQ-1:0] maskQ;
	logic               irqQ;

	//----------------------------------------------------------------------
	// Write strobes.
	assign regOff   = bus.addr[REG_W-1:0];
	assign isPendWr = bus.sel & bus.wrEn & (regOff == INTC_PEND);
	assign isMaskWr = bus.sel & bus.wrEn & (regOff == INTC_MASK);

	// Pending bits, write one to clear; new pulse wins.
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			pendQ <= '0;
			maskQ <= '0;
			irqQ  <= 1'b0;
		end else begin
			if (isPendWr)
				pendQ <= (pendQ & ~bus.wrData[NUM_IRQ-1:0]) | i_irqSrc;
			else
				pendQ <= pendQ | i_irqSrc;
			if (isMaskWr)
				maskQ <= bus.wrData[NUM_IRQ-1:0];
			// Line follows pending bits one cycle late.
			irqQ <= |(pendQ & maskQ);
		end
	end

	assign o_irq = irqQ;

	//----------------------------------------------------------------------
	// Read data.
	always_comb begin
		case (regOff)
			INTC_PEND: bus.rdData = {{(DATA_W-NUM_IRQ){1'b0}}, pendQ};
			INTC_MASK: bus.rdData = {{(DATA_W-NUM_IRQ){1'b0}}, maskQ};
			default:   bus.rdData = '0;
		endcase
	end

endmodule

//--- src/timerSubsys.sv
//--------------------------------------------------------------------------
// Timer subsystem top: two hosts, arbiter, decoder, two timers, IRQ ctrl.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module timerSubsys
	import periphPkg::*;
(
	input  logic              i_clk,
	input  logic              i_rstN,

	// CPU data port.
	input  logic              i_cpuReq,
	input  logic [ADDR_W-1:0] i_cpuAddr,
	input  logic [DATA_W-1:0] i_cpuWrData,
	input  logic              i_cpuWrEn,
	output logic              o_cpuGnt,
	output logic [DATA_W-1:0] o_cpuRdData,

	// Debug port.
	input  logic              i_dbgReq,
	input  logic [ADDR_W-1:0] i_dbgAddr,
	input  logic [DATA_W-1:0] i_dbgWrData,
	input  logic              i_dbgWrEn,
	output logic              o_dbgGnt,
	output logic [DATA_W-1:0] o_dbgRdData,

	// System state and interrupt.
	input  logic              i_smIsBooted,
	input  logic              i_smStartPause,
	output logic              o_irq
);

	logic [NUM_IRQ-1:0] irqSrc;

	// Bus segments.
	memBusIf sharedBus ();
	memBusIf tmr0Bus ();
	memBusIf tmr1Bus ();
	memBusIf intcBus ();

	//----------------------------------------------------------------------
	// Host side.
	busArbiter arbiter_i (
		.i_clk      (i_clk),
		.i_rstN     (i_rstN),
		.i_cpuReq   (i_cpuReq),
		.i_cpuAddr  (i_cpuAddr),
		.i_cpuWrData(i_cpuWrData),
		.i_cpuWrEn  (i_cpuWrEn),
		.o_cpuGnt   (o_cpuGnt),
		.o_cpuRdData(o_cpuRdData),
		.i_dbgReq   (i_dbgReq),
		.i_dbgAddr  (i_dbgAddr),
		.i_dbgWrData(i_dbgWrData),
		.i_dbgWrEn  (i_dbgWrEn),
		.o_dbgGnt   (o_dbgGnt),
		.o_dbgRdData(o_dbgRdData),
		.busM       (sharedBus.host)
	);

	periphDecoder decoder_i (
		.busS (sharedBus.device),
		.tmr0M(tmr0Bus.host),
		.tmr1M(tmr1Bus.host),
		.intcM(intcBus.host)
	);

	//----------------------------------------------------------------------
	// Devices. Timer 0 is source bit 0.
	timer timer0_i (
		.i_clk         (i_clk),
		.i_rstN        (i_rstN),
		.bus           (tmr0Bus.device),
		.i_smIsBooted  (i_smIsBooted),
		.i_smStartPause(i_smStartPause),
		.o_intTMR      (irqSrc[0])
	);

	timer timer1_i (
		.i_clk         (i_clk),
		.i_rstN        (i_rstN),
		.bus           (tmr1Bus.device),
		.i_smIsBooted  (i_smIsBooted),
		.i_smStartPause(i_smStartPause),
		.o_intTMR      (irqSrc[1])
	);

	intCtrl intCtrl_i (
		.i_clk   (i_clk),
		.i_rstN  (i_rstN),
		.bus     (intcBus.device),
		.i_irqSrc(irqSrc),
		.o_irq   (o_irq)
	);

endmodule

//--- tb/timerSubsys_tb.sv
//--------------------------------------------------------------------------
// Testbench for the timer subsystem; runs the operations listed in
// tb/timerVectors.txt over both host ports and checks the responses.
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module timerSubsys_tb
	import periphPkg::*;
();

	logic                         clk;
	logic                         rstN;
	logic                         smIsBooted;
	logic                         smStartPause;
	logic                         irq;

	// Host ports, index 0 is the CPU and index 1 the debug host.
	logic [1:0]                   hostReq;
	logic [1:0][ADDR_W-1:0]       hostAddr;
	logic [1:0][DATA_W-1:0]       hostWrData;
	logic [1:0]                   hostWrEn;
	logic [1:0]                   hostGnt;
	logic [1:0][DATA_W-1:0]       hostRdData;

	// Vector columns.
	byte                          opQ[$];
	hostSel_t                     hostQ[$];
	logic [ADDR_W-1:0]            addrQ[$];
	logic [DATA_W-1:0]            dataQ[$];
	logic [DATA_W-1:0]            expQ[$];

	logic [15:0]                  lfsr;
	logic                         loaded;
	int                           valueErrs;
	int                           otherErrs;

	timerSubsys dut_i (
		.i_clk         (clk),
		.i_rstN        (rstN),
		.i_cpuReq      (hostReq[0]),
		.i_cpuAddr     (hostAddr[0]),
		.i_cpuWrData   (hostWrData[0]),
		.i_cpuWrEn     (hostWrEn[0]),
		.o_cpuGnt      (hostGnt[0]),
		.o_cpuRdData   (hostRdData[0]),
		.i_dbgReq      (hostReq[1]),
		.i_dbgAddr     (hostAddr[1]),
		.i_dbgWrData   (hostWrData[1]),
		.i_dbgWrEn     (hostWrEn[1]),
		.o_dbgGnt      (hostGnt[1]),
		.o_dbgRdData   (hostRdData[1]),
		.i_smIsBooted  (smIsBooted),
		.i_smStartPause(smStartPause),
		.o_irq         (irq)
	);

	// 10 ns clock.
	always #5 clk = ~clk;

	//----------------------------------------------------------------------
	// Galois LFSR, taps 16,14,13,11.
	function automatic logic [15:0] stepLfsr(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One step per bit taken.
	function automatic logic [DATA_W-1:0] randomWord();
		logic [DATA_W-1:0] w;
		int                b;
		w = '0;
		for (b = 0; b < DATA_W; b++) begin
			lfsr = stepLfsr(lfsr);
			w[b] = lfsr[0];
		end
		return w;
	endfunction

	//----------------------------------------------------------------------
	// Compare helpers.
	task automatic checkData(input logic [DATA_W-1:0] actual,
			input logic [DATA_W-1:0] expected, input string msg);
		if (actual !== expected) begin
			$display("Fail %0t: %s read %h, expected %h", $time, msg, actual, expected);
			valueErrs++;
		end
	endtask

	task automatic checkGnt(input hostSel_t actual, input hostSel_t expected, input string msg);
		if (actual !== expected) begin
			$display("Fail %0t: %s went to %s, expected %s", $time, msg, actual.name(),
				expected.name());
			valueErrs++;
		end
	endtask

	//----------------------------------------------------------------------
	// Bus access helpers, entered and left on a falling edge.
	task automatic driveHost(input hostSel_t host, input logic req,
			input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data, input logic wr);
		hostReq[host]    = req;
		hostAddr[host]   = addr;
		hostWrData[host] = data;
		hostWrEn[host]   = wr;
	endtask

	// Holds the request until granted.
	task automatic hostAccess(input hostSel_t host, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] data, input logic wr, output logic [DATA_W-1:0] rd);
		driveHost(host, 1'b1, addr, data, wr);
		#2;
		while (!hostGnt[host]) begin
			@(negedge clk);
			#2;
		end
		// Read data is valid during the grant cycle.
		rd = hostRdData[host];
		@(negedge clk);
		driveHost(host, 1'b0, '0, '0, 1'b0);
	endtask

	// Grant owner now; exactly one host expected.
	task automatic sampleGrant(output hostSel_t who);
		if (hostGnt[0] == hostGnt[1]) begin
			$display("Expected exactly one grant but saw %b at %0t", hostGnt, $time);
			otherErrs++;
		end
		who = hostGnt[1] ? HOST_DBG : HOST_CPU;
	endtask

	// Both hosts write at once; debug targets the other timer.
	task automatic dualWrite(input hostSel_t first, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] cpuData, input logic [DATA_W-1:0] dbgData);
		hostSel_t second;
		hostSel_t who;
		second = (first == HOST_CPU) ? HOST_DBG : HOST_CPU;
		driveHost(HOST_CPU, 1'b1, addr, cpuData, 1'b1);
		driveHost(HOST_DBG, 1'b1, addr ^ ADDR_W'(4), dbgData, 1'b1);
		#2;
		sampleGrant(who);
		checkGnt(who, first, "first grant of dual request");
		@(negedge clk);
		driveHost(who, 1'b0, '0, '0, 1'b0);
		// Waiting host keeps its request stable.
		#2;
		sampleGrant(who);
		checkGnt(who, second, "second grant of dual request");
		@(negedge clk);
		driveHost(HOST_CPU, 1'b0, '0, '0, 1'b0);
		driveHost(HOST_DBG, 1'b0, '0, '0, 1'b0);
	endtask

	task automatic expectIrq(input int maxCycles, input logic level);
		int n;
		n = 0;
		while (irq !== level && n < maxCycles) begin
			@(negedge clk);
			n++;
		end
		if (irq !== level) begin
			$display("Interrupt line did not go to %0d within %0d cycles, at %0t", level,
				maxCycles, $time);
			otherErrs++;
		end
	endtask

	task automatic applyReset();
		rstN = 1'b0;
		repeat (2) @(negedge clk);
		rstN = 1'b1;
	endtask

	//----------------------------------------------------------------------
	// Vector file reader; lines starting with # are skipped.
	task automatic loadVectors();
		int                fd;
		int                code;
		string             op;
		string             rest;
		logic [3:0]        host;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [DATA_W-1:0] expected;
		fd = $fopen("tb/timerVectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open tb/timerVectors.txt");
			otherErrs++;
		end else begin
			code = $fscanf(fd, "%s", op);
			while (code == 1) begin
				if (op.getc(0) == "#") begin
					code = $fgets(rest, fd);
				end else begin
					code = $fscanf(fd, "%h %h %h %h", host, addr, data, expected);
					opQ.push_back(op.getc(0));
					hostQ.push_back(hostSel_t'(host[0]));
					addrQ.push_back(addr);
					dataQ.push_back(data);
					expQ.push_back(expected);
				end
				code = $fscanf(fd, "%s", op);
			end
			$fclose(fd);
		end
	endtask

	//----------------------------------------------------------------------
	// Main sequence.
	initial begin
		logic [DATA_W-1:0] rd;
		clk          = 1'b0;
		rstN         = 1'b0;
		smIsBooted   = 1'b1;
		smStartPause = 1'b0;
		hostReq      = '0;
		hostAddr     = '0;
		hostWrData   = '0;
		hostWrEn     = '0;
		lfsr         = 16'd31804;
		valueErrs    = 0;
		otherErrs    = 0;
		loaded       = 1'b0;
		loadVectors();
		loaded = 1'b1;
		repeat (2) @(negedge clk);
		rstN = 1'b1;
		foreach (opQ[i]) begin
			case (opQ[i])
				"W": hostAccess(hostQ[i], addrQ[i], dataQ[i], 1'b1, rd);
				"R": begin
					hostAccess(hostQ[i], addrQ[i], '0, 1'b0, rd);
					checkData(rd, expQ[i], $sformatf("vector %0d at %h", i, addrQ[i]));
				end
				"N": repeat (dataQ[i]) @(negedge clk);
				"P": begin
					smIsBooted   = dataQ[i][0];
					smStartPause = dataQ[i][1];
				end
				// Background write of random data, then read back.
				"B": begin
					hostAccess(HOST_DBG, addrQ[i], randomWord(), 1'b1, rd);
					hostAccess(HOST_DBG, addrQ[i], '0, 1'b0, rd);
					checkData(rd, expQ[i], $sformatf("vector %0d at %h", i, addrQ[i]));
				end
				"D": dualWrite(hostQ[i], addrQ[i], dataQ[i], expQ[i]);
				"I": expectIrq(int'(dataQ[i]), expQ[i][0]);
				"X": applyReset();
				default: begin
					$display("Unknown opcode in vector %0d", i);
					otherErrs++;
				end
			endcase
		end
		@(negedge clk);
		$display("Errors: %0d value, %0d other, %0d vectors", valueErrs, otherErrs, opQ.size());
		if (valueErrs == 0 && otherErrs == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// Watchdog, 64 cycles per vector.
	initial begin
		wait (loaded);
		repeat (opQ.size() * 64 + 4) @(posedge clk);
		$display("Watchdog expired before all vectors ran");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- tb/timerVectors.txt
# Columns: op host addr data expected, hex after the op letter; host 0 CPU, 1 debug.
# W write, R read, N wait data cycles, P booted=data[0] pause=data[1], B random write+read, D dual write, I irq level, X reset.
W 0 2 1234 0000
R 0 2 0000 1234
W 1 1 00AB 0000
R 0 1 0000 00AB
W 0 6 0040 0000
R 1 6 0000 0040
R 0 3 0000 0000
B 1 D 0000 0000
W 0 1 0000 0000
W 0 0 0031 0000
N 0 0 0014 0000
R 0 1 0000 0005
R 0 0 0000 0031
P 0 0 0003 0000
R 0 1 0000 0005
N 0 0 000A 0000
R 0 1 0000 0005
P 0 0 0000 0000
N 0 0 000A 0000
R 1 1 0000 0005
P 0 0 0001 0000
W 0 0 0000 0000
W 0 6 0003 0000
W 0 9 0002 0000
W 0 4 0001 0000
N 0 0 0005 0000
R 0 5 0000 0001
R 0 8 0000 0002
I 0 0 0008 0001
W 0 4 0000 0000
N 0 0 0004 0000
W 0 8 0002 0000
I 0 0 0004 0000
R 0 8 0000 0000
X 0 0 0000 0000
D 0 2 1111 2222
R 1 6 0000 2222
R 0 2 0000 1111
D 1 1 0A0A 0B0B
R 0 1 0000 0A0A
R 1 5 0000 0B0B

//--- all.f
src/periphPkg.sv
src/memBusIf.sv
src/busArbiter.sv
src/periphDecoder.sv
src/timer.sv
src/intCtrl.sv
src/timerSubsys.sv
tb/timerSubsys_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the timer subsystem testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module timerSubsys_tb -o simv --Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q -x -F '*** PASSED ***' sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
